//--- verilog/stq_pkg.sv
package stq_pkg;

  // ==========================================================================
  // queue geometry
  // ==========================================================================
  localparam int STQ_DEPTH = 8;
  localparam int STQ_IDX_W = 3;
  localparam int STQ_CNT_W = 4;   // 0..STQ_DEPTH inclusive

  localparam int PADDR_W   = 32;
  localparam int ST_DATA_W = 32;
  localparam int DW_BYTES  = 8;
  localparam int DW_DATA_W = 64;
  localparam int DW_OFS_W  = $clog2(DW_BYTES);  // byte offset inside a doubleword

  typedef logic [STQ_IDX_W-1:0] stq_idx_t;
  typedef logic [STQ_DEPTH-1:0] stq_vec_t;
  typedef logic [PADDR_W-1:0]   paddr_t;
  typedef logic [ST_DATA_W-1:0] st_data_t;
  typedef logic [DW_DATA_W-1:0] dw_data_t;
  typedef logic [DW_BYTES-1:0]  byte_en_t;

  typedef enum logic [1:0] {
    ST_B = 2'd0,
    ST_H = 2'd1,
    ST_W = 2'd2
  } st_size_e;

  // bytes touched by a store, placed at its offset in the doubleword
  function automatic byte_en_t gen_be(st_size_e size, logic [DW_OFS_W-1:0] ofs);
    byte_en_t base;
    case (size)
      ST_B:    base = byte_en_t'(8'h01);
      ST_H:    base = byte_en_t'(8'h03);
      ST_W:    base = byte_en_t'(8'h0f);
      default: base = '0;
    endcase
    return base << ofs;
  endfunction

  // store data copied across the whole doubleword
  function automatic dw_data_t gen_dw_data(st_size_e size, st_data_t data);
    case (size)
      ST_B:    return {(DW_DATA_W / 8){data[7:0]}};
      ST_H:    return {(DW_DATA_W / 16){data[15:0]}};
      ST_W:    return {(DW_DATA_W / 32){data[31:0]}};
      default: return '0;
    endcase
  endfunction

endpackage

//--- verilog/stq_view_if.sv
`timescale 1ns/1ps

interface stq_view_if;
  import stq_pkg::*;

  // per-entry status flags
  stq_vec_t valid;
  stq_vec_t addr_ok;
  stq_vec_t data_ok;
  stq_vec_t committed;

  // per-entry payload
  paddr_t   paddr [STQ_DEPTH];
  st_size_e size  [STQ_DEPTH];
  st_data_t data  [STQ_DEPTH];

  modport array (
    output valid, addr_ok, data_ok, committed,
    output paddr, size, data
  );

  modport reader (
    input valid, addr_ok, data_ok, committed,
    input paddr, size, data
  );

endinterface

//--- verilog/stq_ptr_credit.sv
`timescale 1ns/1ps

module stq_ptr_credit (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_alloc,
  input  logic              i_commit,
  input  logic              i_free,
  output stq_pkg::stq_idx_t o_tail,
  output stq_pkg::stq_idx_t o_head,
  output stq_pkg::stq_idx_t o_cmt_idx,
  output logic              o_credit_return
);
  import stq_pkg::*;

  stq_idx_t             r_tail;   // next slot to allocate
  stq_idx_t             r_head;   // oldest store
  stq_idx_t             r_cmt;    // oldest not-yet-committed store
  logic [STQ_CNT_W-1:0] r_count;
  logic                 r_credit_return;

  logic w_full;
  logic w_alloc;

  assign w_full  = (r_count == STQ_CNT_W'(STQ_DEPTH));
  assign w_alloc = i_alloc & !w_full;  // full queue drops the request

  // ==========================================================================
  // pointers
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
      r_head <= '0;
      r_cmt  <= '0;
    end else begin
      if (w_alloc) begin
        r_tail <= r_tail + 1'b1;  // wraps at depth
      end
      if (i_free) begin
        r_head <= r_head + 1'b1;
      end
      if (i_commit) begin
        r_cmt <= r_cmt + 1'b1;
      end
    end
  end

  // occupancy, alloc and free may land on the same edge
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      case ({w_alloc, i_free})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // one credit per freed entry, the cycle after the free
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credit_return <= 1'b0;
    end else begin
      r_credit_return <= i_free;
    end
  end

  assign o_tail          = r_tail;
  assign o_head          = r_head;
  assign o_cmt_idx       = r_cmt;
  assign o_credit_return = r_credit_return;

endmodule

//--- verilog/stq_entry_array.sv
`timescale 1ns/1ps

module stq_entry_array (
  input  logic              i_clk,
  input  logic              i_reset_n,
  // allocation at the tail
  input  logic              i_alloc,
  input  stq_pkg::stq_idx_t i_tail,
  // address and size
  input  logic              i_addr_valid,
  input  stq_pkg::stq_idx_t i_addr_idx,
  input  stq_pkg::paddr_t   i_addr_paddr,
  input  stq_pkg::st_size_e i_addr_size,
  // store data
  input  logic              i_data_valid,
  input  stq_pkg::stq_idx_t i_data_idx,
  input  stq_pkg::st_data_t i_data_value,
  // commit marking
  input  logic              i_commit,
  input  stq_pkg::stq_idx_t i_cmt_idx,
  // release of the head entry
  input  logic              i_free,
  input  stq_pkg::stq_idx_t i_head,
  stq_view_if.array         view
);
  import stq_pkg::*;

  stq_vec_t r_valid;
  stq_vec_t r_addr_ok;
  stq_vec_t r_data_ok;
  stq_vec_t r_committed;

  paddr_t   r_paddr [STQ_DEPTH];
  st_size_e r_size  [STQ_DEPTH];
  st_data_t r_data  [STQ_DEPTH];

  logic w_alloc;

  // tail still occupied means the queue is full
  assign w_alloc = i_alloc & !r_valid[i_tail];

  // ==========================================================================
  // status flags
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= '0;
      r_addr_ok   <= '0;
      r_data_ok   <= '0;
      r_committed <= '0;
    end else begin
      if (w_alloc) begin
        r_valid[i_tail]     <= 1'b1;
        r_addr_ok[i_tail]   <= 1'b0;
        r_data_ok[i_tail]   <= 1'b0;
        r_committed[i_tail] <= 1'b0;
      end
      if (i_addr_valid) begin
        r_addr_ok[i_addr_idx] <= 1'b1;
      end
      if (i_data_valid) begin
        r_data_ok[i_data_idx] <= 1'b1;
      end
      if (i_commit) begin
        r_committed[i_cmt_idx] <= 1'b1;
      end
      // head leaves, last so it wins over stray updates
      if (i_free) begin
        r_valid[i_head]     <= 1'b0;
        r_addr_ok[i_head]   <= 1'b0;
        r_data_ok[i_head]   <= 1'b0;
        r_committed[i_head] <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    if (i_addr_valid) begin
      r_paddr[i_addr_idx] <= i_addr_paddr;
      r_size[i_addr_idx]  <= i_addr_size;
    end
    if (i_data_valid) begin
      r_data[i_data_idx] <= i_data_value;
    end
  end

  assign view.valid     = r_valid;
  assign view.addr_ok   = r_addr_ok;
  assign view.data_ok   = r_data_ok;
  assign view.committed = r_committed;

  for (genvar e = 0; e < STQ_DEPTH; e++) begin : g_view
    assign view.paddr[e] = r_paddr[e];
    assign view.size[e]  = r_size[e];
    assign view.data[e]  = r_data[e];
  end

endmodule

//--- verilog/stq_fwd_search.sv
`timescale 1ns/1ps

module stq_fwd_search (
  stq_view_if.reader        view,
  input  stq_pkg::stq_idx_t i_head,
  input  logic              i_fwd_valid,
  input  stq_pkg::paddr_t   i_fwd_paddr,
  input  stq_pkg::byte_en_t i_fwd_be,
  output logic              o_fwd_hit,
  output stq_pkg::byte_en_t o_fwd_be,
  output stq_pkg::dw_data_t o_fwd_data,
  output logic              o_fwd_hazard
);
  import stq_pkg::*;

  byte_en_t w_be [STQ_DEPTH];  // bytes written by each entry
  stq_vec_t w_same_dw;
  stq_vec_t w_overlap;
  stq_vec_t w_match;
  stq_vec_t w_hazard;

  stq_idx_t w_idx;
  stq_idx_t w_sel;
  logic     w_found;

  // ==========================================================================
  // per-entry compare
  // ==========================================================================
  always_comb begin
    for (int e = 0; e < STQ_DEPTH; e++) begin
      w_be[e] = gen_be(view.size[e], view.paddr[e][DW_OFS_W-1:0]);
      w_same_dw[e] = (view.paddr[e][PADDR_W-1:DW_OFS_W] == i_fwd_paddr[PADDR_W-1:DW_OFS_W]);
      w_overlap[e] = |(w_be[e] & i_fwd_be);
      w_match[e] = view.valid[e] & view.addr_ok[e] & view.data_ok[e] &
                   w_same_dw[e] & w_overlap[e];
      // unknown address, or known overlap still missing data
      w_hazard[e] = view.valid[e] &
                    (!view.addr_ok[e] |
                     (w_same_dw[e] & w_overlap[e] & !view.data_ok[e]));
    end
  end

  // walk from the head, later matches are younger and win
  always_comb begin
    w_idx   = i_head;
    w_sel   = i_head;
    w_found = 1'b0;
    for (int k = 0; k < STQ_DEPTH; k++) begin
      w_idx = i_head + STQ_IDX_W'(k);
      if (w_match[w_idx]) begin
        w_sel   = w_idx;
        w_found = 1'b1;
      end
    end
  end

  assign o_fwd_hit    = i_fwd_valid & w_found;
  assign o_fwd_be     = o_fwd_hit ? (w_be[w_sel] & i_fwd_be) : '0;
  assign o_fwd_data   = gen_dw_data(view.size[w_sel], view.data[w_sel]);
  assign o_fwd_hazard = i_fwd_valid & (|w_hazard);

endmodule

//--- verilog/stq_drain.sv
`timescale 1ns/1ps

module stq_drain (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  stq_pkg::stq_idx_t i_head,
  input  logic              i_wr_ready,
  stq_view_if.reader        view,
  output logic              o_free,
  output logic              o_wr_valid,
  output stq_pkg::paddr_t   o_wr_paddr,
  output stq_pkg::dw_data_t o_wr_data,
  output stq_pkg::byte_en_t o_wr_be
);
  import stq_pkg::*;

  typedef enum logic {
    DR_IDLE  = 1'b0,
    DR_WRITE = 1'b1
  } drain_state_e;

  drain_state_e r_state;

  paddr_t   r_wr_paddr;
  dw_data_t r_wr_data;
  byte_en_t r_wr_be;

  logic w_eligible;
  logic w_accept;

  // head is complete and committed
  assign w_eligible = view.valid[i_head] & view.committed[i_head] &
                      view.addr_ok[i_head] & view.data_ok[i_head];
  assign w_accept   = (r_state == DR_WRITE) & i_wr_ready;

  // ==========================================================================
  // write FSM
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= DR_IDLE;
    end else begin
      case (r_state)
        DR_IDLE:  if (w_eligible) r_state <= DR_WRITE;
        DR_WRITE: if (i_wr_ready) r_state <= DR_IDLE;  // idle one cycle after each write
        default:  r_state <= DR_IDLE;
      endcase
    end
  end

  // write fields captured on launch, held under back-pressure
  always_ff @(posedge i_clk) begin
    if ((r_state == DR_IDLE) && w_eligible) begin
      r_wr_paddr <= {view.paddr[i_head][PADDR_W-1:DW_OFS_W], {DW_OFS_W{1'b0}}};
      r_wr_data  <= gen_dw_data(view.size[i_head], view.data[i_head]);
      r_wr_be    <= gen_be(view.size[i_head], view.paddr[i_head][DW_OFS_W-1:0]);
    end
  end

  assign o_free     = w_accept;  // head advances on the accepting edge
  assign o_wr_valid = (r_state == DR_WRITE);
  assign o_wr_paddr = r_wr_paddr;
  assign o_wr_data  = r_wr_data;
  assign o_wr_be    = r_wr_be;

endmodule

//--- verilog/stq_top.sv
`timescale 1ns/1ps

module stq_top (
  input  logic              i_clk,
  input  logic              i_reset_n,
  // allocation
  input  logic              i_alloc_valid,
  output stq_pkg::stq_idx_t o_alloc_idx,
  // address arrival
  input  logic              i_addr_valid,
  input  stq_pkg::stq_idx_t i_addr_idx,
  input  stq_pkg::paddr_t   i_addr_paddr,
  input  stq_pkg::st_size_e i_addr_size,
  // data arrival
  input  logic              i_data_valid,
  input  stq_pkg::stq_idx_t i_data_idx,
  input  stq_pkg::st_data_t i_data_value,
  // commit of the oldest uncommitted store
  input  logic              i_commit,
  // load lookup
  input  logic              i_fwd_valid,
  input  stq_pkg::paddr_t   i_fwd_paddr,
  input  stq_pkg::byte_en_t i_fwd_be,
  output logic              o_fwd_hit,
  output stq_pkg::byte_en_t o_fwd_be,
  output stq_pkg::dw_data_t o_fwd_data,
  output logic              o_fwd_hazard,
  // credits back to the producer
  output logic              o_credit_return,
  // cache write
  output logic              o_wr_valid,
  output stq_pkg::paddr_t   o_wr_paddr,
  output stq_pkg::dw_data_t o_wr_data,
  output stq_pkg::byte_en_t o_wr_be,
  input  logic              i_wr_ready
);
  import stq_pkg::*;

  stq_idx_t w_tail;
  stq_idx_t w_head;
  stq_idx_t w_cmt_idx;
  logic     w_free;

  stq_view_if u_view ();

  stq_ptr_credit u_ptr (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_alloc         (i_alloc_valid),
    .i_commit        (i_commit),
    .i_free          (w_free),
    .o_tail          (w_tail),
    .o_head          (w_head),
    .o_cmt_idx       (w_cmt_idx),
    .o_credit_return (o_credit_return)
  );

  stq_entry_array u_array (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_alloc      (i_alloc_valid),
    .i_tail       (w_tail),
    .i_addr_valid (i_addr_valid),
    .i_addr_idx   (i_addr_idx),
    .i_addr_paddr (i_addr_paddr),
    .i_addr_size  (i_addr_size),
    .i_data_valid (i_data_valid),
    .i_data_idx   (i_data_idx),
    .i_data_value (i_data_value),
    .i_commit     (i_commit),
    .i_cmt_idx    (w_cmt_idx),
    .i_free       (w_free),
    .i_head       (w_head),
    .view         (u_view.array)
  );

  stq_fwd_search u_fwd (
    .view         (u_view.reader),
    .i_head       (w_head),
    .i_fwd_valid  (i_fwd_valid),
    .i_fwd_paddr  (i_fwd_paddr),
    .i_fwd_be     (i_fwd_be),
    .o_fwd_hit    (o_fwd_hit),
    .o_fwd_be     (o_fwd_be),
    .o_fwd_data   (o_fwd_data),
    .o_fwd_hazard (o_fwd_hazard)
  );

  stq_drain u_drain (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_head     (w_head),
    .i_wr_ready (i_wr_ready),
    .view       (u_view.reader),
    .o_free     (w_free),
    .o_wr_valid (o_wr_valid),
    .o_wr_paddr (o_wr_paddr),
    .o_wr_data  (o_wr_data),
    .o_wr_be    (o_wr_be)
  );

  assign o_alloc_idx = w_tail;  // new store lands at the tail

endmodule

//--- bench/stq_top_props.sv
`timescale 1ns/1ps

module stq_top_props (
  input logic              i_clk,
  input logic              i_reset_n,
  input logic              i_alloc_valid,
  input stq_pkg::stq_vec_t i_valid,
  input stq_pkg::stq_idx_t i_tail,
  input logic              i_wr_valid,
  input logic              i_wr_ready,
  input stq_pkg::paddr_t   i_wr_paddr,
  input stq_pkg::dw_data_t i_wr_data,
  input stq_pkg::byte_en_t i_wr_be,
  input logic              i_credit_return
);

  int unsigned fail_count = 0;  // failed assertions so far

  // tail slot must still be free
  a_alloc_not_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc_valid |-> !i_valid[i_tail])
    else begin
      $error("allocation into a full store queue");
      fail_count++;
    end

  // pending write holds its fields
  a_wr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid && !i_wr_ready |=> i_wr_valid && $stable(i_wr_paddr) &&
                                  $stable(i_wr_data) && $stable(i_wr_be))
    else begin
      $error("cache write changed while it was not accepted");
      fail_count++;
    end

  a_credit_after_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid && i_wr_ready |=> i_credit_return)
    else begin
      $error("no credit returned after an accepted write");
      fail_count++;
    end

endmodule

bind stq_top stq_top_props u_props (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_alloc_valid   (i_alloc_valid),
  .i_valid         (u_view.valid),
  .i_tail          (w_tail),
  .i_wr_valid      (o_wr_valid),
  .i_wr_ready      (i_wr_ready),
  .i_wr_paddr      (o_wr_paddr),
  .i_wr_data       (o_wr_data),
  .i_wr_be         (o_wr_be),
  .i_credit_return (o_credit_return)
);

//--- bench/stq_top_tb.sv
`timescale 1ns/1ps

module stq_top_tb;
  import stq_pkg::*;

  localparam CASES_FILE = "bench/stq_top_cases.txt";

  logic i_clk, i_reset_n, i_alloc_valid, i_addr_valid, i_data_valid, i_commit;
  logic i_fwd_valid, i_wr_ready, o_fwd_hit, o_fwd_hazard, o_credit_return, o_wr_valid;
  stq_idx_t o_alloc_idx, i_addr_idx, i_data_idx;
  paddr_t   i_addr_paddr, i_fwd_paddr, o_wr_paddr;
  st_size_e i_addr_size;
  st_data_t i_data_value;
  byte_en_t i_fwd_be, o_fwd_be, o_wr_be;
  dw_data_t o_fwd_data, o_wr_data;

  // one step of the cases file
  logic [8*16-1:0]  name;
  logic [8*160-1:0] line_buf;
  logic [1:0]       size_v;
  logic             exp_wr_valid, exp_hit, exp_hazard;
  paddr_t           exp_wr_paddr;
  dw_data_t         exp_wr_data, exp_fwd_data;
  byte_en_t         exp_wr_be, exp_fwd_be;

  int       fd, n, n_cases, steps_done, credits;
  logic     cases_counted;
  stq_idx_t model_tail;   // where the next store should land
  logic     prev_accept;  // write taken on the last edge

  stq_top u_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic stop_run(input string why);
    $display("%0s", why);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_run($sformatf("MISMATCH %0s %0s expected %0h actual %0h", name, what, exp, act));
    end
  endtask

  // ==========================================================================
  // one cycle, inputs already applied 5 ns after the edge
  // ==========================================================================
  task automatic run_step();
    i_addr_size = st_size_e'(size_v);
    if (o_credit_return) credits++;  // slot was freed on the last edge
    if (i_alloc_valid) begin
      if (credits == 0) stop_run("cases file allocates with no credit left");
      credits--;
    end
    #90;  // sample just before the next edge
    check_value("alloc_idx", model_tail, o_alloc_idx);
    check_value("credit_return", prev_accept, o_credit_return);
    check_value("wr_valid", exp_wr_valid, o_wr_valid);
    if (exp_wr_valid) begin
      check_value("wr_paddr", exp_wr_paddr, o_wr_paddr);
      check_value("wr_data", exp_wr_data, o_wr_data);
      check_value("wr_be", exp_wr_be, o_wr_be);
    end
    if (i_fwd_valid) begin
      check_value("fwd_hit", exp_hit, o_fwd_hit);
      check_value("fwd_hazard", exp_hazard, o_fwd_hazard);
      if (exp_hit) begin
        check_value("fwd_be", exp_fwd_be, o_fwd_be);
        check_value("fwd_data", exp_fwd_data, o_fwd_data);
      end
    end
    if (i_alloc_valid) model_tail++;  // wraps with the index width
    prev_accept = exp_wr_valid & i_wr_ready;
    steps_done++;
    @(posedge i_clk);
    #5;
  endtask

  initial begin
    {i_reset_n, i_alloc_valid, i_addr_valid, i_data_valid, i_commit} = '0;
    {i_fwd_valid, i_wr_ready, i_addr_idx, i_data_idx} = '0;
    {i_addr_paddr, i_data_value, i_fwd_paddr, i_fwd_be} = '0;
    i_addr_size   = ST_B;
    credits       = STQ_DEPTH;
    model_tail    = '0;
    prev_accept   = 1'b0;
    steps_done    = 0;
    n_cases       = 0;
    cases_counted = 1'b0;

    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) stop_run("cannot open the cases file");
    while ($fgets(line_buf, fd) != 0) begin
      if ($sscanf(line_buf, "%s", name) == 1 && name != "#") n_cases++;
    end
    $fclose(fd);
    cases_counted = 1'b1;

    fd = $fopen(CASES_FILE, "r");
    repeat (10) @(posedge i_clk);
    #5 i_reset_n = 1'b1;
    while ($fgets(line_buf, fd) != 0) begin
      if ($sscanf(line_buf, "%s", name) == 1 && name != "#") begin
        n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, i_alloc_valid, i_addr_valid, i_addr_idx, i_addr_paddr, size_v,
                    i_data_valid, i_data_idx, i_data_value, i_commit, i_wr_ready,
                    i_fwd_valid, i_fwd_paddr, i_fwd_be, exp_wr_valid, exp_wr_paddr,
                    exp_wr_data, exp_wr_be, exp_hit, exp_fwd_be, exp_fwd_data, exp_hazard);
        if (n != 22) stop_run("cases file has a line with missing fields");
        run_step();
      end
    end
    $fclose(fd);

    if (steps_done == n_cases && steps_done > 0 && u_dut.u_props.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("%0d of %0d steps run, %0d assertion failures",
               steps_done, n_cases, u_dut.u_props.fail_count);
      $display("Checks failed");
      $fatal(1, "run failed");
    end
  end

  initial begin
    wait (u_dut.u_props.fail_count != 0);
    stop_run("a bound assertion on the DUT handshakes failed");
  end

  // watchdog, sized from the number of steps
  initial begin
    wait (cases_counted);
    repeat (n_cases + 50) @(posedge i_clk);
    $display("timeout before all steps of the cases file were run");
    $display("Checks failed");
    $fatal(1, "timeout");
  end

endmodule

//--- stq_top.f
verilog/stq_pkg.sv
verilog/stq_view_if.sv
verilog/stq_ptr_credit.sv
verilog/stq_entry_array.sv
verilog/stq_fwd_search.sv
verilog/stq_drain.sv
verilog/stq_top.sv
bench/stq_top_props.sv
bench/stq_top_tb.sv

//--- bench/stq_top_cases.txt
# name alloc addr_v addr_idx paddr size(0=B 1=H 2=W) data_v data_idx data commit wr_ready fwd_v fwd_paddr fwd_be
# expected: wr_valid wr_paddr wr_data wr_be fwd_hit fwd_be fwd_data fwd_hazard, all hex
reset_alloc 1 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
alloc 1 1 0 103 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
alloc 1 0 0 0 0 1 1 1234 0 1 0 0 0 0 0 0 0 0 0 0 0
alloc 1 1 2 104 2 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
forward 0 1 1 206 1 1 0 a5 0 1 1 100 ff 0 0 0 0 0 0 0 1
forward 0 1 3 105 0 0 0 0 0 1 1 100 0f 0 0 0 0 1 08 a5a5a5a5a5a5a5a5 1
forward 0 0 0 0 0 1 2 deadbeef 0 1 1 100 f0 0 0 0 0 0 0 0 1
forward 0 0 0 0 0 1 3 77 0 1 1 100 f0 0 0 0 0 1 f0 deadbeefdeadbeef 1
forward 0 0 0 0 0 0 0 0 1 1 1 100 f0 0 0 0 0 1 20 7777777777777777 0
commit 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0
backpress 1 0 0 0 0 0 0 0 0 0 0 0 0 1 100 a5a5a5a5a5a5a5a5 08 0 0 0 0
backpress 1 0 0 0 0 0 0 0 0 0 0 0 0 1 100 a5a5a5a5a5a5a5a5 08 0 0 0 0
backpress 1 0 0 0 0 0 0 0 0 1 0 0 0 1 100 a5a5a5a5a5a5a5a5 08 0 0 0 0
drain 1 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
wrap 1 0 0 0 0 0 0 0 1 1 0 0 0 1 200 1234123412341234 c0 0 0 0 0
wrap 1 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
sizes 0 0 0 0 0 0 0 0 1 1 0 0 0 1 100 deadbeefdeadbeef f0 0 0 0 0
sizes 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
sizes 0 0 0 0 0 0 0 0 0 1 0 0 0 1 100 7777777777777777 20 0 0 0 0
ooo 0 1 4 3fe 1 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0
ooo 0 0 0 0 0 1 4 beef 0 1 0 0 0 0 0 0 0 0 0 0 0
ooo 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
ooo 0 0 0 0 0 0 0 0 0 1 0 0 0 1 3f8 beefbeefbeefbeef c0 0 0 0 0
ooo 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
